/* sink_settings.svh */
/*
  sink streamer settings
  widths, FIFO depths and counter width shared by the store streamer
*/

`ifndef SINK_SETTINGS_SVH
`define SINK_SETTINGS_SVH

// width of one stream word from the datapath
`define SINK_STREAM_DW 32

// memory word is 32 bits wider than the stream, room for any byte offset
`define SINK_TCDM_DW (`SINK_STREAM_DW + 32)

// byte address width
`define SINK_ADDR_W 32

// length and transfer counters
`define SINK_CNT_W 16

// decoupling FIFO depths
`define SINK_ADDR_FIFO_DEPTH 2
`define SINK_STORE_FIFO_DEPTH 2

`endif

/* sink_pkg.sv */
/*
  sink streamer package
  FSM state encoding and the payload types carried by the two FIFOs
*/

`include "sink_settings.svh"

package sink_pkg;

  // streamer control states
  typedef enum logic [1:0] {
    STREAMER_IDLE    = 2'b00,
    STREAMER_WORKING = 2'b01,
    STREAMER_DONE    = 2'b10
  } streamer_state_e;

  // one byte address from the address generator
  typedef struct packed {
    logic [`SINK_ADDR_W-1:0] addr;
  } addr_entry_t;

  // one store towards memory, data already lane aligned
  typedef struct packed {
    logic [`SINK_ADDR_W-1:0]    add;
    logic [`SINK_TCDM_DW-1:0]   data;
    logic [`SINK_TCDM_DW/8-1:0] be;
  } store_req_t;

endpackage

/* sink_fifo.sv */
/*
  sink FIFO
  circular buffer with valid/ready on both sides and a typed payload
*/

`timescale 1ns/1ps

module sink_fifo #(
  parameter int unsigned DEPTH = 2,
  parameter type         payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     clear_i,
  input  logic     push_valid_i,
  input  payload_t push_data_i,
  output logic     push_ready_o,
  output logic     pop_valid_o,
  output payload_t pop_data_o,
  input  logic     pop_ready_i,
  output logic     empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t             mem_q [DEPTH];
  logic [PTR_W-1:0]     wr_ptr_q;
  logic [PTR_W-1:0]     rd_ptr_q;
  logic [CNT_W-1:0]     count_q;
  logic                 full;
  logic                 push;
  logic                 pop;

  assign full    = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);

  // a full FIFO still takes a push when the head leaves in the same cycle
  assign push_ready_o = ~full | pop_ready_i;
  assign pop_valid_o  = ~empty_o;
  assign pop_data_o   = mem_q[rd_ptr_q];

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_valid_o & pop_ready_i;

  // pointers and occupancy
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // count only moves when exactly one side fires
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // storage, data shows on the pop side from the next cycle
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

/* sink_addressgen.sv */
/*
  sink address generator
  turns base, lengths and strides into a stream of byte addresses
*/

`timescale 1ns/1ps

`include "sink_settings.svh"

module sink_addressgen (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clear_i,
  input  logic                      start_i,
  input  logic [`SINK_ADDR_W-1:0]   base_addr_i,
  input  logic [`SINK_CNT_W-1:0]    tot_len_i,
  input  logic [`SINK_CNT_W-1:0]    line_len_i,
  input  logic [`SINK_ADDR_W-1:0]   word_stride_i,
  input  logic [`SINK_ADDR_W-1:0]   line_stride_i,
  input  logic                      addr_ready_i,
  output logic                      addr_valid_o,
  output sink_pkg::addr_entry_t     addr_o,
  output logic                      done_o
);

  logic                    active_q;
  logic                    done_q;
  logic [`SINK_CNT_W-1:0]  word_cnt_q;
  logic [`SINK_CNT_W-1:0]  tot_cnt_q;
  logic [`SINK_ADDR_W-1:0] addr_q;
  logic [`SINK_ADDR_W-1:0] line_addr_q;
  logic                    addr_hs;
  logic                    last_word;
  logic                    last_addr;

  // an address leaves only while the pattern is running
  assign addr_hs   = active_q & addr_ready_i;
  // last word of the current line
  assign last_word = (word_cnt_q == line_len_i - 1'b1);
  // last address of the whole pattern
  assign last_addr = (tot_cnt_q == tot_len_i - 1'b1);

  // control: activity flag, counters and done pulse
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q   <= 1'b0;
      done_q     <= 1'b0;
      word_cnt_q <= '0;
      tot_cnt_q  <= '0;
    end else if (clear_i) begin
      active_q   <= 1'b0;
      done_q     <= 1'b0;
      word_cnt_q <= '0;
      tot_cnt_q  <= '0;
    end else begin
      done_q <= addr_hs & last_addr;
      if (start_i) begin
        // first address is valid on the next cycle
        active_q   <= 1'b1;
        word_cnt_q <= '0;
        tot_cnt_q  <= '0;
      end else if (addr_hs) begin
        tot_cnt_q <= tot_cnt_q + 1'b1;
        if (last_addr) begin
          active_q <= 1'b0;
        end
        // restart the line count at the end of a line
        if (last_word) begin
          word_cnt_q <= '0;
        end else begin
          word_cnt_q <= word_cnt_q + 1'b1;
        end
      end
    end
  end

  // address datapath, strides are byte amounts so misaligned is fine
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q      <= base_addr_i;
      line_addr_q <= base_addr_i;
    end else if (addr_hs) begin
      if (last_word) begin
        // next line starts one line stride after the previous line start
        addr_q      <= line_addr_q + line_stride_i;
        line_addr_q <= line_addr_q + line_stride_i;
      end else begin
        addr_q <= addr_q + word_stride_i;
      end
    end
  end

  assign addr_valid_o = active_q;
  assign addr_o.addr  = addr_q;
  assign done_o       = done_q;

endmodule

/* sink_streamer.sv */
/*
  sink streamer core
  control FSM, transfer counter and the shifter that forms store requests
*/

`timescale 1ns/1ps

`include "sink_settings.svh"

module sink_streamer (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  // control
  input  logic                          req_start_i,
  input  logic [`SINK_CNT_W-1:0]        tot_len_i,
  input  logic                          addrgen_done_i,
  output logic                          addrgen_start_o,
  output logic                          ready_start_o,
  output logic                          done_o,
  // address FIFO pop side
  input  logic                          apop_valid_i,
  input  logic [`SINK_ADDR_W-1:0]       apop_addr_i,
  output logic                          apop_ready_o,
  // stream input
  input  logic                          stream_valid_i,
  input  logic [`SINK_STREAM_DW-1:0]    stream_data_i,
  input  logic [`SINK_STREAM_DW/8-1:0]  stream_strb_i,
  output logic                          stream_ready_o,
  // store FIFO push side
  input  logic                          st_ready_i,
  input  logic                          store_empty_i,
  output logic                          st_valid_o,
  output sink_pkg::store_req_t          st_req_o
);

  localparam int unsigned BE_W = `SINK_TCDM_DW / 8;

  sink_pkg::streamer_state_e cs, ns;

  logic [`SINK_CNT_W-1:0]   cnt_q;
  logic                     done_q;
  logic                     busy;
  logic                     fire;
  logic                     finish;
  logic [1:0]               offset;
  logic [`SINK_TCDM_DW-1:0] data_shift;
  logic [BE_W-1:0]          be_shift;

  assign busy = (cs != sink_pkg::STREAMER_IDLE);

  // a beat, an address and a free store slot are needed together
  assign fire           = busy & stream_valid_i & apop_valid_i & st_ready_i;
  assign stream_ready_o = busy & apop_valid_i & st_ready_i;
  assign apop_ready_o   = busy & stream_valid_i & st_ready_i;
  assign st_valid_o     = busy & stream_valid_i & apop_valid_i;

  // byte offset inside the 32-bit word
  assign offset = apop_addr_i[1:0];

  // move data and strobes up by the byte offset, spill lands in the upper lanes
  assign data_shift = `SINK_TCDM_DW'(stream_data_i) << {offset, 3'b000};
  assign be_shift   = BE_W'(stream_strb_i) << offset;

  // request goes to the word aligned address, bytes outside the beat stay disabled
  always_comb begin
    st_req_o.add  = {apop_addr_i[`SINK_ADDR_W-1:2], 2'b00};
    st_req_o.data = data_shift;
    st_req_o.be   = be_shift;
  end

  // next state and start handshake
  always_comb begin
    ns              = cs;
    finish          = 1'b0;
    ready_start_o   = 1'b0;
    addrgen_start_o = 1'b0;
    case (cs)
      sink_pkg::STREAMER_IDLE: begin
        ready_start_o = 1'b1;
        if (req_start_i) begin
          addrgen_start_o = 1'b1;
          ns              = sink_pkg::STREAMER_WORKING;
        end
      end
      sink_pkg::STREAMER_WORKING: begin
        // all addresses issued
        if (addrgen_done_i) begin
          ns = sink_pkg::STREAMER_DONE;
        end
      end
      sink_pkg::STREAMER_DONE: begin
        // all beats counted and every store has left for memory
        if (cnt_q == tot_len_i && store_empty_i) begin
          finish = 1'b1;
          ns     = sink_pkg::STREAMER_IDLE;
        end
      end
      default: begin
        ns = sink_pkg::STREAMER_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cs <= sink_pkg::STREAMER_IDLE;
    end else if (clear_i) begin
      cs <= sink_pkg::STREAMER_IDLE;
    end else begin
      cs <= ns;
    end
  end

  // transfer counter, one step per accepted beat
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (clear_i || finish) begin
      cnt_q <= '0;
    end else if (fire) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // done is a registered pulse, shows in the first IDLE cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= 1'b0;
    end else if (clear_i) begin
      done_q <= 1'b0;
    end else begin
      done_q <= finish;
    end
  end

  assign done_o = done_q;

endmodule

/* sink_top.sv */
/*
  sink streamer top
  address generator, address FIFO, streamer and store FIFO towards the TCDM
*/

`timescale 1ns/1ps

`include "sink_settings.svh"

module sink_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  // control port
  input  logic                          req_start_i,
  input  logic [`SINK_ADDR_W-1:0]       base_addr_i,
  input  logic [`SINK_CNT_W-1:0]        tot_len_i,
  input  logic [`SINK_CNT_W-1:0]        line_len_i,
  input  logic [`SINK_ADDR_W-1:0]       word_stride_i,
  input  logic [`SINK_ADDR_W-1:0]       line_stride_i,
  output logic                          ready_start_o,
  output logic                          done_o,
  output logic                          addrgen_done_o,
  // stream input
  input  logic                          stream_valid_i,
  input  logic [`SINK_STREAM_DW-1:0]    stream_data_i,
  input  logic [`SINK_STREAM_DW/8-1:0]  stream_strb_i,
  output logic                          stream_ready_o,
  // memory port
  output logic                          tcdm_req_o,
  input  logic                          tcdm_gnt_i,
  output logic [`SINK_ADDR_W-1:0]       tcdm_add_o,
  output logic [`SINK_TCDM_DW-1:0]      tcdm_data_o,
  output logic [`SINK_TCDM_DW/8-1:0]    tcdm_be_o
);

  logic                  addrgen_start;
  logic                  addr_valid;
  logic                  addr_ready;
  sink_pkg::addr_entry_t addr_entry;
  logic                  apop_valid;
  logic                  apop_ready;
  sink_pkg::addr_entry_t apop_entry;
  logic                  st_valid;
  logic                  st_ready;
  sink_pkg::store_req_t  st_req;
  sink_pkg::store_req_t  tcdm_entry;
  logic                  store_empty;

  sink_addressgen i_addressgen (
    .clk_i         ( clk_i          ),
    .rst_ni        ( rst_ni         ),
    .clear_i       ( clear_i        ),
    .start_i       ( addrgen_start  ),
    .base_addr_i   ( base_addr_i    ),
    .tot_len_i     ( tot_len_i      ),
    .line_len_i    ( line_len_i     ),
    .word_stride_i ( word_stride_i  ),
    .line_stride_i ( line_stride_i  ),
    .addr_ready_i  ( addr_ready     ),
    .addr_valid_o  ( addr_valid     ),
    .addr_o        ( addr_entry     ),
    .done_o        ( addrgen_done_o )
  );

  // decouples address generation from stream arrival
  sink_fifo #(
    .DEPTH     ( `SINK_ADDR_FIFO_DEPTH  ),
    .payload_t ( sink_pkg::addr_entry_t )
  ) i_addr_fifo (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .clear_i      ( clear_i    ),
    .push_valid_i ( addr_valid ),
    .push_data_i  ( addr_entry ),
    .push_ready_o ( addr_ready ),
    .pop_valid_o  ( apop_valid ),
    .pop_data_o   ( apop_entry ),
    .pop_ready_i  ( apop_ready ),
    .empty_o      (            )
  );

  sink_streamer i_streamer (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .clear_i         ( clear_i         ),
    .req_start_i     ( req_start_i     ),
    .tot_len_i       ( tot_len_i       ),
    .addrgen_done_i  ( addrgen_done_o  ),
    .addrgen_start_o ( addrgen_start   ),
    .ready_start_o   ( ready_start_o   ),
    .done_o          ( done_o          ),
    .apop_valid_i    ( apop_valid      ),
    .apop_addr_i     ( apop_entry.addr ),
    .apop_ready_o    ( apop_ready      ),
    .stream_valid_i  ( stream_valid_i  ),
    .stream_data_i   ( stream_data_i   ),
    .stream_strb_i   ( stream_strb_i   ),
    .stream_ready_o  ( stream_ready_o  ),
    .st_ready_i      ( st_ready        ),
    .store_empty_i   ( store_empty     ),
    .st_valid_o      ( st_valid        ),
    .st_req_o        ( st_req          )
  );

  // holds stores while the memory withholds its grant
  sink_fifo #(
    .DEPTH     ( `SINK_STORE_FIFO_DEPTH ),
    .payload_t ( sink_pkg::store_req_t  )
  ) i_store_fifo (
    .clk_i        ( clk_i       ),
    .rst_ni       ( rst_ni      ),
    .clear_i      ( clear_i     ),
    .push_valid_i ( st_valid    ),
    .push_data_i  ( st_req      ),
    .push_ready_o ( st_ready    ),
    .pop_valid_o  ( tcdm_req_o  ),
    .pop_data_o   ( tcdm_entry  ),
    .pop_ready_i  ( tcdm_gnt_i  ),
    .empty_o      ( store_empty )
  );

  assign tcdm_add_o  = tcdm_entry.add;
  assign tcdm_data_o = tcdm_entry.data;
  assign tcdm_be_o   = tcdm_entry.be;

endmodule

/* sink_properties.sv */
/*
  sink streamer protocol checks
  bound to the top level, watches the memory port and the start/done handshake
*/

`timescale 1ns/1ps

`include "sink_settings.svh"

module sink_properties (
  input logic                        clk_i,
  input logic                        rst_ni,
  input logic                        clear_i,
  input logic                        req_start_i,
  input logic                        ready_start_i,
  input logic                        done_i,
  input logic                        tcdm_req_i,
  input logic                        tcdm_gnt_i,
  input logic [`SINK_ADDR_W-1:0]     tcdm_add_i,
  input logic [`SINK_TCDM_DW-1:0]    tcdm_data_i,
  input logic [`SINK_TCDM_DW/8-1:0]  tcdm_be_i
);

  // number of failed assertions
  int unsigned fail_count = 0;

  // a store waiting for its grant keeps request and fields, a clear drops it
  req_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    (!clear_i && tcdm_req_i && !tcdm_gnt_i) |=> (tcdm_req_i && $stable(tcdm_add_i) &&
                                                 $stable(tcdm_data_i) &&
                                                 $stable(tcdm_be_i)))
    else begin
      fail_count++;
      $error("tcdm request dropped or changed before its grant");
    end

  // done is a single cycle pulse
  done_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    done_i |=> !done_i)
    else begin
      fail_count++;
      $error("done stayed high for more than one cycle");
    end

  // a taken start leaves IDLE, so ready drops
  start_leaves_idle_a: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    (req_start_i && ready_start_i) |=> !ready_start_i)
    else begin
      fail_count++;
      $error("ready_start stayed high after a start");
    end

  // outside IDLE ready only comes back together with done, a clear returns to IDLE
  ready_low_busy_a: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    (!clear_i && !ready_start_i) |=> (!ready_start_i || done_i))
    else begin
      fail_count++;
      $error("ready_start rose while the streamer was busy");
    end

endmodule

bind sink_top sink_properties i_sink_properties (
  .clk_i         ( clk_i          ),
  .rst_ni        ( rst_ni         ),
  .clear_i       ( clear_i        ),
  .req_start_i   ( req_start_i    ),
  .ready_start_i ( ready_start_o  ),
  .done_i        ( done_o         ),
  .tcdm_req_i    ( tcdm_req_o     ),
  .tcdm_gnt_i    ( tcdm_gnt_i     ),
  .tcdm_add_i    ( tcdm_add_o     ),
  .tcdm_data_i   ( tcdm_data_o    ),
  .tcdm_be_i     ( tcdm_be_o      )
);

/* tb_sink_top.sv */
/*
  testbench for the sink streamer
  drives access patterns and stream words, models the TCDM and checks memory
*/

`timescale 1ns/1ps

`include "sink_settings.svh"

module tb_sink_top;

  // words over all tests, the cleared run counted in full
  localparam int unsigned TOTAL_LEN      = 16 + 3 * 6 + 12 + 8 + 32 + 16 + 16;
  localparam int unsigned TIMEOUT_CYCLES = 40 * TOTAL_LEN;

  logic                          clk_i;
  logic                          rst_ni;
  logic                          clear_i;
  logic                          req_start_i;
  logic [`SINK_ADDR_W-1:0]       base_addr_i;
  logic [`SINK_CNT_W-1:0]        tot_len_i;
  logic [`SINK_CNT_W-1:0]        line_len_i;
  logic [`SINK_ADDR_W-1:0]       word_stride_i;
  logic [`SINK_ADDR_W-1:0]       line_stride_i;
  logic                          ready_start_o;
  logic                          done_o;
  logic                          addrgen_done_o;
  logic                          stream_valid_i;
  logic [`SINK_STREAM_DW-1:0]    stream_data_i;
  logic [`SINK_STREAM_DW/8-1:0]  stream_strb_i;
  logic                          stream_ready_o;
  logic                          tcdm_req_o;
  logic                          tcdm_gnt_i;
  logic [`SINK_ADDR_W-1:0]       tcdm_add_o;
  logic [`SINK_TCDM_DW-1:0]      tcdm_data_o;
  logic [`SINK_TCDM_DW/8-1:0]    tcdm_be_o;

  // byte addressed memory and its expected image
  logic [7:0]  mem     [bit [31:0]];
  logic [7:0]  ref_mem [bit [31:0]];
  integer      seed = 32'h52b6aded;
  int unsigned error_count = 0;
  int unsigned done_count = 0;
  int unsigned addrgen_done_count = 0;
  int unsigned cycle_count = 0;
  logic        grant_random = 1'b0;

  sink_top i_sink_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // TCDM model, only enabled lanes land, lane k at byte add + k
  always @(posedge clk_i) begin
    if (tcdm_req_o && tcdm_gnt_i) begin
      for (int k = 0; k < `SINK_TCDM_DW / 8; k++) begin
        if (tcdm_be_o[k]) begin
          mem[tcdm_add_o + 32'(k)] = tcdm_data_o[8*k +: 8];
        end
      end
    end
  end

  // grant either always on or about three cycles in four
  always @(negedge clk_i) begin
    tcdm_gnt_i = grant_random ? (($random(seed) & 3) != 0) : 1'b1;
  end

  // done pulses and the run limit
  always @(posedge clk_i) begin
    if (done_o) begin
      done_count++;
    end
    if (addrgen_done_o) begin
      addrgen_done_count++;
    end
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("timeout: run still busy after %0d cycles", cycle_count);
      error_count++;
      report_and_finish();
    end
  end

  // i-th address of a two-level pattern
  function automatic logic [31:0] pattern_addr(input logic [31:0] base, input int unsigned idx,
                                               input int unsigned line_len,
                                               input logic [31:0] word_stride,
                                               input logic [31:0] line_stride);
    int unsigned line_idx;
    int unsigned word_idx;
    line_idx = idx / line_len;
    word_idx = idx % line_len;
    return base + 32'(line_idx) * line_stride + 32'(word_idx) * word_stride;
  endfunction

  task automatic report_and_finish();
    int unsigned sva_fails;
    sva_fails = i_sink_top.i_sink_properties.fail_count;
    $display("summary: %0d check errors, %0d assertion failures", error_count, sva_fails);
    if (error_count == 0 && sva_fails == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  endtask

  // reset or clear state seen at the next edge
  task automatic check_idle(input string when_txt);
    @(posedge clk_i);
    if (ready_start_o !== 1'b1) begin
      $display("[ERROR] %s: ready_start_o = 0x%0h, expected 0x1", when_txt, ready_start_o);
      error_count++;
    end
    if (done_o !== 1'b0) begin
      $display("[ERROR] %s: done_o = 0x%0h, expected 0x0", when_txt, done_o);
      error_count++;
    end
    if (addrgen_done_o !== 1'b0) begin
      $display("[ERROR] %s: addrgen_done_o = 0x%0h, expected 0x0", when_txt, addrgen_done_o);
      error_count++;
    end
    if (tcdm_req_o !== 1'b0) begin
      $display("[ERROR] %s: tcdm_req_o = 0x%0h, expected 0x0", when_txt, tcdm_req_o);
      error_count++;
    end
    if (stream_ready_o !== 1'b0) begin
      $display("[ERROR] %s: stream_ready_o = 0x%0h, expected 0x0", when_txt, stream_ready_o);
      error_count++;
    end
  endtask

  // program the pattern and hold start until it is taken
  task automatic start_pattern(input logic [31:0] base, input int unsigned len,
                               input int unsigned line_len, input logic [31:0] word_stride,
                               input logic [31:0] line_stride);
    @(negedge clk_i);
    base_addr_i   = base;
    tot_len_i     = `SINK_CNT_W'(len);
    line_len_i    = `SINK_CNT_W'(line_len);
    word_stride_i = word_stride;
    line_stride_i = line_stride;
    req_start_i   = 1'b1;
    do @(posedge clk_i); while (!ready_start_o);
    @(negedge clk_i);
    req_start_i = 1'b0;
  endtask

  // one stream beat after some idle cycles
  task automatic send_word(input logic [31:0] data, input logic [3:0] strb,
                           input int unsigned gaps);
    repeat (gaps) @(negedge clk_i);
    stream_valid_i = 1'b1;
    stream_data_i  = data;
    stream_strb_i  = strb;
    do @(posedge clk_i); while (!stream_ready_o);
    @(negedge clk_i);
    stream_valid_i = 1'b0;
  endtask

  // every expected byte present and no stray byte written
  task automatic compare_memory(input string name);
    foreach (ref_mem[a]) begin
      if (!mem.exists(a)) begin
        $display("%s: byte at 0x%08h was never written", name, a);
        error_count++;
      end else if (mem[a] !== ref_mem[a]) begin
        $display("[ERROR] %s: mem[0x%08h] = 0x%02h, expected 0x%02h", name, a, mem[a],
                 ref_mem[a]);
        error_count++;
      end
    end
    foreach (mem[a]) begin
      if (!ref_mem.exists(a)) begin
        $display("%s: byte at 0x%08h written with 0x%02h, should be untouched", name, a,
                 mem[a]);
        error_count++;
      end
    end
  endtask

  // full transfer: program, stream, wait for done, then check memory
  task automatic run_pattern(input string name, input logic [31:0] base, input int unsigned len,
                             input int unsigned line_len, input logic [31:0] word_stride,
                             input logic [31:0] line_stride, input bit rand_strb,
                             input int unsigned gap_max);
    logic [31:0] data;
    logic [3:0]  strb;
    logic [31:0] addr;
    int unsigned gaps;
    int unsigned done_before;
    int unsigned agen_before;
    mem.delete();
    ref_mem.delete();
    done_before = done_count;
    agen_before = addrgen_done_count;
    start_pattern(base, len, line_len, word_stride, line_stride);
    for (int unsigned i = 0; i < len; i++) begin
      data = $random(seed);
      strb = rand_strb ? 4'($random(seed)) : 4'hf;
      gaps = (gap_max == 0) ? 0 : $unsigned($random(seed)) % (gap_max + 1);
      addr = pattern_addr(base, i, line_len, word_stride, line_stride);
      // expected image, byte j of the word at addr + j
      for (int j = 0; j < 4; j++) begin
        if (strb[j]) begin
          ref_mem[addr + 32'(j)] = data[8*j +: 8];
        end
      end
      send_word(data, strb, gaps);
    end
    do @(posedge clk_i); while (!done_o);
    if (ready_start_o !== 1'b1) begin
      $display("[ERROR] %s: ready_start_o = 0x%0h after done, expected 0x1", name,
               ready_start_o);
      error_count++;
    end
    repeat (3) @(posedge clk_i);
    if (done_count != done_before + 1) begin
      $display("[ERROR] %s: done_o pulse count = 0x%0h, expected 0x1", name,
               done_count - done_before);
      error_count++;
    end
    // the address generator finishes once per pattern
    if (addrgen_done_count != agen_before + 1) begin
      $display("[ERROR] %s: addrgen_done_o pulse count = 0x%0h, expected 0x1", name,
               addrgen_done_count - agen_before);
      error_count++;
    end
    compare_memory(name);
  endtask

  // clear part way through, then the design must be idle again
  task automatic clear_mid_transfer();
    int unsigned done_before;
    int unsigned agen_before;
    done_before = done_count;
    agen_before = addrgen_done_count;
    start_pattern(32'h0000_3000, 16, 16, 32'd4, 32'd0);
    for (int unsigned i = 0; i < 5; i++) begin
      send_word($random(seed), 4'hf, 0);
    end
    @(negedge clk_i);
    clear_i = 1'b1;
    @(negedge clk_i);
    clear_i = 1'b0;
    check_idle("after clear");
    if (done_count != done_before) begin
      $display("[ERROR] clear: done_o pulse count = 0x%0h, expected 0x0",
               done_count - done_before);
      error_count++;
    end
    // only a few of the 16 addresses left before the clear
    if (addrgen_done_count != agen_before) begin
      $display("[ERROR] clear: addrgen_done_o pulse count = 0x%0h, expected 0x0",
               addrgen_done_count - agen_before);
      error_count++;
    end
  endtask

  initial begin
    rst_ni         = 1'b0;
    clear_i        = 1'b0;
    req_start_i    = 1'b0;
    base_addr_i    = '0;
    tot_len_i      = '0;
    line_len_i     = '0;
    word_stride_i  = '0;
    line_stride_i  = '0;
    stream_valid_i = 1'b0;
    stream_data_i  = '0;
    stream_strb_i  = '0;
    tcdm_gnt_i     = 1'b0;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    check_idle("after reset");

    // aligned linear store, grant always high
    run_pattern("aligned", 32'h0000_1000, 16, 16, 32'd4, 32'd0, 1'b0, 0);
    // misaligned bases, upper lanes carry the spill
    run_pattern("offset 1", 32'h0000_2001, 6, 6, 32'd4, 32'd0, 1'b0, 0);
    run_pattern("offset 2", 32'h0000_2102, 6, 6, 32'd4, 32'd0, 1'b0, 0);
    run_pattern("offset 3", 32'h0000_2203, 6, 6, 32'd4, 32'd0, 1'b0, 0);
    // lines of 4 words, 64 bytes apart
    run_pattern("two-level", 32'h0000_4000, 12, 4, 32'd4, 32'd64, 1'b0, 0);
    run_pattern("partial strobe", 32'h0000_5000, 8, 8, 32'd4, 32'd0, 1'b1, 0);
    // stalls from both sides
    grant_random = 1'b1;
    run_pattern("random stalls", 32'h0000_6001, 32, 8, 32'd4, 32'h40, 1'b0, 3);
    clear_mid_transfer();
    run_pattern("after clear", 32'h0000_7000, 16, 4, 32'd4, 32'd32, 1'b0, 2);

    report_and_finish();
  end

endmodule

/* flist.f */
+incdir+.
sink_pkg.sv
sink_fifo.sv
sink_addressgen.sv
sink_streamer.sv
sink_top.sv
sink_properties.sv
tb_sink_top.sv

/* Makefile */
# Verilator build and run for the sink streamer testbench

VERILATOR ?= verilator
TOP       ?= tb_sink_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
